// ==== rtl/opl_dims_pkg.sv ====
// mixer dimensions: data widths, bank sizes and the host register map
package opl_dims_pkg;

    // bank size
    localparam int NUM_CHANNELS = 9; // two-operator channels
    localparam int NUM_OPERATORS = 18; // two per channel

    // datapath widths
    localparam int OP_OUT_WIDTH = 13; // signed operator result
    localparam int SAMPLE_WIDTH = 16; // signed output sample
    localparam int ACC_WIDTH = 18; // 9 channels of 2x full operator range

    // output clamp limits
    localparam int SAMPLE_MAX = 2**(SAMPLE_WIDTH - 1) - 1;
    localparam int SAMPLE_MIN = -(2**(SAMPLE_WIDTH - 1));

    // host bus
    localparam int REG_ADDR_WIDTH = 4; // word address
    localparam int REG_DATA_WIDTH = 8;

    // register map: one control byte per channel, words 0 to 8
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL_BASE = 4'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CTRL_LAST = 4'(NUM_CHANNELS - 1);

    // bit positions within a channel control byte
    localparam int CTRL_CNT_BIT = 0; // 1 = additive, 0 = fm
    localparam int CTRL_LEFT_BIT = 4; // left output enable
    localparam int CTRL_RIGHT_BIT = 5; // right output enable

    // operator layout of the bank
    localparam int OPS_PER_GROUP = 3; // channels per operator group
    localparam int SECOND_OP_OFFSET = 3; // second operator sits 3 above first

    // index widths derived from the counts
    localparam int CH_NUM_WIDTH = $clog2(NUM_CHANNELS);
    localparam int OP_NUM_WIDTH = $clog2(NUM_OPERATORS);

endpackage

// ==== rtl/opl_types_pkg.sv ====
// shared record types of the mixer: bus writes, operator results, samples, fsm states
package opl_types_pkg;

    // one register write from the host port, valid for a single cycle
    typedef struct packed {
        logic valid;
        logic [opl_dims_pkg::REG_ADDR_WIDTH-1:0] address;
        logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] data;
    } reg_wr_t;

    // one operator result from the external engine
    typedef struct packed {
        logic valid;
        logic [opl_dims_pkg::OP_NUM_WIDTH-1:0] op_num;
        logic signed [opl_dims_pkg::OP_OUT_WIDTH-1:0] op_out;
    } operator_out_t;

    // clamped stereo output
    typedef struct packed {
        logic signed [opl_dims_pkg::SAMPLE_WIDTH-1:0] left;
        logic signed [opl_dims_pkg::SAMPLE_WIDTH-1:0] right;
    } stereo_sample_t;

    // channel walk of the mixer
    typedef enum logic [2:0] {
        IDLE, // waiting for ops_done
        LOAD_SECOND, // address second operator
        LOAD_FIRST, // latch second, address first and control
        ACCUMULATE, // add channel into enabled sides
        DONE // clamp and publish
    } mixer_state_t;

endpackage

// ==== rtl/dual_port_ram.sv ====
// simple dual port memory with registered read, contents zeroed by reset
`timescale 1ns/1ns

module dual_port_ram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input logic clk,
    input logic rst_n,
    input logic we,
    input logic [$clog2(DEPTH)-1:0] waddr,
    input logic [WIDTH-1:0] wdata,
    input logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[waddr] <= wdata;
            end
            rdata <= mem[raddr]; // one cycle read latency
        end
    end

endmodule

// ==== rtl/wb_reg_port.sv ====
// wishbone classic slave turning host writes into single-cycle register write records
`timescale 1ns/1ns

module wb_reg_port (
    input logic clk,
    input logic rst_n,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [opl_dims_pkg::REG_ADDR_WIDTH-1:0] adr,
    input logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] dat_w,
    output logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] dat_r,
    output logic ack,
    output opl_types_pkg::reg_wr_t reg_wr
);

    logic access; // new bus cycle seen this clock
    logic wr_access;

    // ack gates itself so a held strobe completes only once
    assign access = cyc && stb && !ack;
    assign wr_access = access && we;

    // registers are write-only, reads return zero
    assign dat_r = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= access; // one cycle, no wait states
        end
    end

    // write record lines up with the ack cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wr <= '0;
        end else begin
            reg_wr.valid <= wr_access;
            if (wr_access) begin
                reg_wr.address <= adr;
                reg_wr.data <= dat_w;
            end
        end
    end

endmodule

// ==== rtl/channel_mixer.sv ====
// channel mixer summing the nine channels of each operator pass into a clamped stereo sample
`timescale 1ns/1ns

module channel_mixer (
    input logic clk,
    input logic rst_n,
    input opl_types_pkg::reg_wr_t reg_wr,
    input opl_types_pkg::operator_out_t op_in,
    input logic ops_done,
    output opl_types_pkg::stereo_sample_t sample,
    output logic sample_valid
);

    // running context of one mixing pass
    typedef struct packed {
        logic [opl_dims_pkg::CH_NUM_WIDTH-1:0] channel_num;
        logic [opl_dims_pkg::OP_NUM_WIDTH-1:0] op_num; // first operator of channel
        logic signed [opl_dims_pkg::OP_OUT_WIDTH-1:0] second_out;
        logic signed [opl_dims_pkg::ACC_WIDTH-1:0] acc_l;
        logic signed [opl_dims_pkg::ACC_WIDTH-1:0] acc_r;
    } mix_ctx_t;

    opl_types_pkg::mixer_state_t state;
    opl_types_pkg::mixer_state_t next_state;
    mix_ctx_t ctx;
    mix_ctx_t next_ctx;

    logic ctrl_we;
    logic [opl_dims_pkg::REG_ADDR_WIDTH-1:0] ctrl_waddr;
    logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] ctrl_byte;
    logic [opl_dims_pkg::OP_NUM_WIDTH-1:0] op_raddr;
    logic [opl_dims_pkg::OP_OUT_WIDTH-1:0] op_rdata;

    logic cnt;
    logic add_l;
    logic add_r;
    logic signed [opl_dims_pkg::OP_OUT_WIDTH:0] channel_out; // one bit of headroom
    logic latch_sample;
    logic sample_latched; // sample register loaded last cycle

    // saturate an accumulator into the sample range
    function automatic logic signed [opl_dims_pkg::SAMPLE_WIDTH-1:0] clamp(
        input logic signed [opl_dims_pkg::ACC_WIDTH-1:0] value
    );
        if (value > opl_dims_pkg::SAMPLE_MAX) begin
            return opl_dims_pkg::SAMPLE_WIDTH'(opl_dims_pkg::SAMPLE_MAX);
        end else if (value < opl_dims_pkg::SAMPLE_MIN) begin
            return opl_dims_pkg::SAMPLE_WIDTH'(opl_dims_pkg::SAMPLE_MIN);
        end
        return value[opl_dims_pkg::SAMPLE_WIDTH-1:0];
    endfunction

    // control bytes live at words 0 to 8 and other words are dropped
    assign ctrl_waddr = reg_wr.address - opl_dims_pkg::REG_CTRL_BASE;
    assign ctrl_we = reg_wr.valid
        && reg_wr.address >= opl_dims_pkg::REG_CTRL_BASE
        && reg_wr.address <= opl_dims_pkg::REG_CTRL_LAST;

    dual_port_ram #(
        .WIDTH(opl_dims_pkg::REG_DATA_WIDTH),
        .DEPTH(opl_dims_pkg::NUM_CHANNELS)
    ) ctrl_mem (
        .clk(clk),
        .rst_n(rst_n),
        .we(ctrl_we),
        .waddr(ctrl_waddr),
        .wdata(reg_wr.data),
        .raddr(ctx.channel_num), // read back in ACCUMULATE
        .rdata(ctrl_byte)
    );

    dual_port_ram #(
        .WIDTH(opl_dims_pkg::OP_OUT_WIDTH),
        .DEPTH(opl_dims_pkg::NUM_OPERATORS)
    ) op_mem (
        .clk(clk),
        .rst_n(rst_n),
        .we(op_in.valid), // engine writes are always taken
        .waddr(op_in.op_num),
        .wdata(op_in.op_out),
        .raddr(op_raddr),
        .rdata(op_rdata)
    );

    // second operator is read first and held while the first arrives
    assign op_raddr = (state == opl_types_pkg::LOAD_SECOND)
        ? ctx.op_num + opl_dims_pkg::OP_NUM_WIDTH'(opl_dims_pkg::SECOND_OP_OFFSET)
        : ctx.op_num;

    assign cnt = ctrl_byte[opl_dims_pkg::CTRL_CNT_BIT];
    assign add_l = ctrl_byte[opl_dims_pkg::CTRL_LEFT_BIT];
    assign add_r = ctrl_byte[opl_dims_pkg::CTRL_RIGHT_BIT];

    // additive mode sums both operators and fm keeps only the carrier
    assign channel_out = cnt ? $signed(op_rdata) + ctx.second_out : ctx.second_out;

    always_comb begin
        next_state = state;
        next_ctx = ctx;
        latch_sample = 1'b0;

        case (state)
            opl_types_pkg::IDLE: begin
                if (ops_done) begin
                    next_state = opl_types_pkg::LOAD_SECOND;
                end
            end
            opl_types_pkg::LOAD_SECOND: begin
                next_state = opl_types_pkg::LOAD_FIRST; // op_mem addressed at second
            end
            opl_types_pkg::LOAD_FIRST: begin
                next_state = opl_types_pkg::ACCUMULATE;
                next_ctx.second_out = $signed(op_rdata);
            end
            opl_types_pkg::ACCUMULATE: begin
                if (add_l) begin
                    next_ctx.acc_l = ctx.acc_l + channel_out;
                end
                if (add_r) begin
                    next_ctx.acc_r = ctx.acc_r + channel_out;
                end

                if (ctx.channel_num == opl_dims_pkg::NUM_CHANNELS - 1) begin
                    next_state = opl_types_pkg::DONE;
                end else begin
                    next_state = opl_types_pkg::LOAD_SECOND;
                    next_ctx.channel_num = ctx.channel_num + 1'b1;
                    // end of a group of three skips the group's second operators
                    if (ctx.channel_num % opl_dims_pkg::OPS_PER_GROUP
                            == opl_dims_pkg::OPS_PER_GROUP - 1) begin
                        next_ctx.op_num = ctx.op_num + opl_dims_pkg::OP_NUM_WIDTH'(
                            opl_dims_pkg::SECOND_OP_OFFSET + 1);
                    end else begin
                        next_ctx.op_num = ctx.op_num + 1'b1;
                    end
                end
            end
            opl_types_pkg::DONE: begin
                next_state = opl_types_pkg::IDLE;
                next_ctx = '0; // fresh sums for the next pass
                latch_sample = 1'b1;
            end
            default: begin
                next_state = opl_types_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= opl_types_pkg::IDLE;
            ctx <= '0;
        end else begin
            state <= next_state;
            ctx <= next_ctx;
        end
    end

    // sample holds until the next pass finishes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample <= '0;
            sample_latched <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_latched <= latch_sample;
            sample_valid <= sample_latched; // flag follows the clamped sample by a cycle
            if (latch_sample) begin
                sample.left <= clamp(ctx.acc_l);
                sample.right <= clamp(ctx.acc_r);
            end
        end
    end

endmodule

// ==== rtl/opl_mix_top.sv ====
// top of the mixing stage: host register port in front of the channel mixer
`timescale 1ns/1ns

module opl_mix_top (
    input logic clk,
    input logic rst_n,

    // wishbone classic host port
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [opl_dims_pkg::REG_ADDR_WIDTH-1:0] adr,
    input logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] dat_w,
    output logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] dat_r,
    output logic ack,

    // operator engine side
    input opl_types_pkg::operator_out_t op_in,
    input logic ops_done,

    // stereo output
    output opl_types_pkg::stereo_sample_t sample,
    output logic sample_valid
);

    opl_types_pkg::reg_wr_t reg_wr; // host write, one cycle

    wb_reg_port u_wb_reg_port (
        .clk(clk),
        .rst_n(rst_n),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack(ack),
        .reg_wr(reg_wr)
    );

    channel_mixer u_channel_mixer (
        .clk(clk),
        .rst_n(rst_n),
        .reg_wr(reg_wr),
        .op_in(op_in),
        .ops_done(ops_done),
        .sample(sample),
        .sample_valid(sample_valid)
    );

endmodule

// ==== tests/tb_opl_mix.sv ====
// testbench for the fm channel mixing stage with directed rows, random rows and bus checks
`timescale 1ns/1ns

module tb_opl_mix;

    localparam int NUM_DIRECTED = 8;
    localparam int NUM_RANDOM = 8;
    localparam int TOTAL_ROWS = NUM_DIRECTED + NUM_RANDOM + 1; // last row is the bus row
    localparam int TIMEOUT_CYCLES = TOTAL_ROWS * 120 + 200;
    localparam int MIX_LATENCY = 29; // edges from the ops_done sampling edge to sample_valid
    localparam int WAIT_LIMIT = 40;

    // one directed row with its control byte, operator values and expected sample
    typedef struct packed {
        logic [7:0] ctrl;
        logic signed [12:0] first;
        logic signed [12:0] second;
        logic signed [15:0] exp_left;
        logic signed [15:0] exp_right;
    } mix_row_t;

    logic clk = 1'b0;
    logic rst_n;
    logic cyc;
    logic stb;
    logic we;
    logic [opl_dims_pkg::REG_ADDR_WIDTH-1:0] adr;
    logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] dat_w;
    logic [opl_dims_pkg::REG_DATA_WIDTH-1:0] dat_r;
    logic ack;
    opl_types_pkg::operator_out_t op_in;
    logic ops_done;
    opl_types_pkg::stereo_sample_t sample;
    logic sample_valid;

    mix_row_t rows [NUM_DIRECTED];
    logic [7:0] ctrl_vals [opl_dims_pkg::NUM_CHANNELS]; // per channel control bytes
    logic signed [12:0] op_vals [opl_dims_pkg::NUM_OPERATORS];
    int seed = 32'h7fe3_b3b3;
    int errors = 0;
    int cycle_count = 0;
    int got_left;
    int got_right;

    opl_mix_top dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .dat_w(dat_w),
        .dat_r(dat_r),
        .ack(ack),
        .op_in(op_in),
        .ops_done(ops_done),
        .sample(sample),
        .sample_valid(sample_valid)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic mix_row_t make_row(input logic [7:0] ctrl, input int first,
                                          input int second, input int left, input int right);
        mix_row_t row;
        row.ctrl = ctrl;
        row.first = 13'(first);
        row.second = 13'(second);
        row.exp_left = 16'(left);
        row.exp_right = 16'(right);
        return row;
    endfunction

    // reference mix with operator pairing, connection, routing and clamp
    function automatic int mix_reference(input bit right_side);
        int sum;
        int first;
        int second;
        int value;
        logic [7:0] ctrl;
        sum = 0;
        for (int c = 0; c < opl_dims_pkg::NUM_CHANNELS; c++) begin
            ctrl = ctrl_vals[c];
            first = c + 3 * (c / 3);
            second = first + 3;
            value = int'(op_vals[second]);
            if (ctrl[opl_dims_pkg::CTRL_CNT_BIT]) begin
                value = value + int'(op_vals[first]);
            end
            if (right_side ? ctrl[opl_dims_pkg::CTRL_RIGHT_BIT]
                           : ctrl[opl_dims_pkg::CTRL_LEFT_BIT]) begin
                sum = sum + value;
            end
        end
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return sum;
    endfunction

    // single wishbone write with ack expected one edge after the strobe
    task automatic bus_write(input int address, input logic [7:0] data);
        int edges;
        edges = 0;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        adr <= 4'(address);
        dat_w <= data;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack && edges < 4);
        if (!ack) begin
            $display("bus write to address %0d was never acknowledged", address);
            errors++;
        end else begin
            check_value("ack delay", 1, edges);
        end
        check_value("dat_r", 0, int'(dat_r));
        @(posedge clk); // strobe still high at this edge
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        @(negedge clk);
        check_value("ack", 0, int'(ack));
    endtask

    task automatic write_operator(input int num, input logic signed [12:0] value);
        @(posedge clk);
        op_in.valid <= 1'b1;
        op_in.op_num <= 5'(num);
        op_in.op_out <= value;
    endtask

    task automatic load_row();
        for (int c = 0; c < opl_dims_pkg::NUM_CHANNELS; c++) begin
            bus_write(c, ctrl_vals[c]);
        end
        for (int o = 0; o < opl_dims_pkg::NUM_OPERATORS; o++) begin
            write_operator(o, op_vals[o]);
        end
        @(posedge clk);
        op_in.valid <= 1'b0;
    endtask

    // pulse ops_done, time sample_valid and compare the sample
    task automatic measure_row(input int row, input string kind, input int exp_left,
                               input int exp_right);
        int edges;
        int errors_before;
        bit seen;
        errors_before = errors;
        edges = 0;
        seen = 1'b0;
        @(posedge clk);
        ops_done <= 1'b1;
        @(posedge clk); // mixer samples ops_done here
        ops_done <= 1'b0;
        while (!seen && edges < WAIT_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = sample_valid;
        end
        if (!seen) begin
            $display("row %0d: sample_valid never rose after ops_done", row);
            errors++;
        end else begin
            check_value("sample_valid delay", MIX_LATENCY, edges);
            got_left = int'(sample.left);
            got_right = int'(sample.right);
            check_value("sample.left", exp_left, got_left);
            check_value("sample.right", exp_right, got_right);
            @(negedge clk);
            check_value("sample_valid", 0, int'(sample_valid)); // one cycle only
        end
        $display("row %0d (%s): left %0d right %0d, %s", row, kind, got_left, got_right,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        rst_n <= 1'b0;
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        adr <= '0;
        dat_w <= '0;
        op_in <= '0;
        ops_done <= 1'b0;

        rows[0] = make_row(8'h31, 100, 200, 2700, 2700); // additive both sides
        rows[1] = make_row(8'h30, 1000, -150, -1350, -1350); // fm ignores first
        rows[2] = make_row(8'h11, 50, 25, 675, 0); // left only
        rows[3] = make_row(8'h21, -40, -60, 0, -900); // right only
        rows[4] = make_row(8'h01, 300, 400, 0, 0); // no output enables
        rows[5] = make_row(8'h31, 4000, 4000, 32767, 32767);
        rows[6] = make_row(8'h31, -4096, -4096, -32768, -32768);
        rows[7] = make_row(8'h30, -4096, 3000, 27000, 27000);

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("ack", 0, int'(ack));
        check_value("sample_valid", 0, int'(sample_valid));
        check_value("sample.left", 0, int'(sample.left));
        check_value("sample.right", 0, int'(sample.right));

        for (int r = 0; r < NUM_DIRECTED; r++) begin
            for (int c = 0; c < opl_dims_pkg::NUM_CHANNELS; c++) begin
                ctrl_vals[c] = rows[r].ctrl;
            end
            for (int o = 0; o < opl_dims_pkg::NUM_OPERATORS; o++) begin
                op_vals[o] = ((o % 6) < 3) ? rows[r].first : rows[r].second;
            end
            load_row();
            measure_row(r, "directed", int'(rows[r].exp_left), int'(rows[r].exp_right));
        end

        for (int r = 0; r < NUM_RANDOM; r++) begin
            for (int c = 0; c < opl_dims_pkg::NUM_CHANNELS; c++) begin
                ctrl_vals[c] = 8'($random(seed));
            end
            for (int o = 0; o < opl_dims_pkg::NUM_OPERATORS; o++) begin
                op_vals[o] = 13'($random(seed));
            end
            load_row();
            measure_row(NUM_DIRECTED + r, "random", mix_reference(1'b0), mix_reference(1'b1));
        end

        // unmapped register must leave the last mix unchanged
        bus_write(12, 8'h00);
        measure_row(TOTAL_ROWS - 1, "bus", mix_reference(1'b0), mix_reference(1'b1));

        $display("%0d rows run, %0d errors", TOTAL_ROWS, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/opl_dims_pkg.sv
rtl/opl_types_pkg.sv
rtl/dual_port_ram.sv
rtl/wb_reg_port.sv
rtl/channel_mixer.sv
rtl/opl_mix_top.sv
tests/tb_opl_mix.sv
